// File: midi_pkg.sv
// note event and voice command formats
// used between the note input, the voice allocator and the voices
package midi_pkg;

    localparam int KEY_BITS = 7;  // midi key number
    localparam int VEL_BITS = 7;  // midi velocity

    // decoded note event from the midi side
    // one cycle strobe qualifies it at the top level
    typedef struct packed {
        logic                on;        // 1 note on, 0 note off
        logic [KEY_BITS-1:0] key;
        logic [VEL_BITS-1:0] velocity;
    } note_event_t;

    // command to a single voice
    // start and stop are one cycle pulses, never both
    typedef struct packed {
        logic                start;     // (re)trigger attack
        logic                stop;      // go to release
        logic [KEY_BITS-1:0] key;       // pitch for start
        logic [VEL_BITS-1:0] velocity;  // peak level for start
    } voice_cmd_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# compile and run the synthesizer testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_synthesizer -f src.f -o tb_synthesizer

# a failed run exits nonzero, the log decides
./obj_dir/tb_synthesizer > sim.log 2>&1 || true
cat sim.log

if grep -q "Test FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

// File: src.f
synth_pkg.sv
midi_pkg.sv
voice_allocator.sv
synth_voice.sv
voice_mixer.sv
synthesizer.sv
tb_synthesizer.sv

// File: synth_pkg.sv
// synthesizer configuration shared by the voices and the mixer
// import where audio widths, envelope steps or pitch lookup are needed
package synth_pkg;

    localparam int ENV_BITS   = 16;  // envelope level width
    localparam int PHASE_BITS = 24;  // phase accumulator width

    localparam logic [ENV_BITS-1:0] ATTACK_STEP  = 16'd256;  // rise per trig
    localparam logic [ENV_BITS-1:0] RELEASE_STEP = 16'd128;  // fall per trig

    typedef enum logic [1:0] {
        ENV_IDLE    = 2'd0,
        ENV_ATTACK  = 2'd1,
        ENV_SUSTAIN = 2'd2,
        ENV_RELEASE = 2'd3
    } env_state_t;

    // ceil(log2(value)), zero for value 1
    function automatic int clogb2(input int value);
        int v;
        int n;
        v = value - 1;
        n = 0;
        while (v > 0) begin
            n++;
            v = v >> 1;
        end
        return n;
    endfunction

    // key to phase increment
    // bottom octave table for a 48 kHz trig rate, shifted up per octave
    function automatic logic [PHASE_BITS-1:0] key_to_inc(input logic [6:0] key);
        logic [13:0] base;
        logic [3:0]  octave;
        logic [3:0]  semi;
        octave = 4'(key / 7'd12);
        semi   = 4'(key % 7'd12);
        case (semi)
            4'd1:    base = 14'd3028;
            4'd2:    base = 14'd3208;
            4'd3:    base = 14'd3398;
            4'd4:    base = 14'd3600;
            4'd5:    base = 14'd3815;
            4'd6:    base = 14'd4041;
            4'd7:    base = 14'd4282;
            4'd8:    base = 14'd4536;
            4'd9:    base = 14'd4806;
            4'd10:   base = 14'd5092;
            4'd11:   base = 14'd5395;
            default: base = 14'd2858;  // C, key 0 is 8.18 Hz
        endcase
        return PHASE_BITS'(base) << octave;
    endfunction

endpackage

// File: synth_voice.sv
// single synth voice with sawtooth oscillator and linear envelope
// driven by commands from the allocator, sample updated on each trig
`timescale 1ns/1ps

module synth_voice #(
    parameter int AUD_BIT_DEPTH = 24
) (
    input  logic                            reg_clk,
    input  logic                            rst,
    input  logic                            trig,    // sample strobe
    input  midi_pkg::voice_cmd_t            cmd,
    output logic                            free,    // high while idle
    output logic signed [AUD_BIT_DEPTH-1:0] sample
);
    import synth_pkg::*;

    localparam int SAW_BITS  = 16;                   // oscillator bits used
    localparam int PROD_BITS = SAW_BITS + ENV_BITS;  // signed product range

    env_state_t                 state;
    env_state_t                 state_n;
    logic [ENV_BITS-1:0]        env;
    logic [ENV_BITS-1:0]        env_n;
    logic [ENV_BITS:0]          env_sum;    // attack sum with carry
    logic [ENV_BITS-1:0]        peak;       // attack target
    logic [PHASE_BITS-1:0]      phase;
    logic [PHASE_BITS-1:0]      phase_n;
    logic [PHASE_BITS-1:0]      phase_inc;
    logic signed [SAW_BITS-1:0] saw;
    logic signed [PROD_BITS:0]  prod;

    //////////////////////////////////////////////////////////////////////
    // oscillator
    //////////////////////////////////////////////////////////////////////

    assign phase_n = trig ? phase + phase_inc : phase;
    assign saw     = phase_n[PHASE_BITS-1 -: SAW_BITS];  // ramp read as signed

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            phase     <= '0;
            phase_inc <= '0;
        end else begin
            if (cmd.start) begin
                phase_inc <= key_to_inc(cmd.key);
            end
            phase <= phase_n;  // free running, no reset on start
        end
    end

    always_ff @(posedge reg_clk) begin
        if (cmd.start) begin
            peak <= ENV_BITS'(cmd.velocity) << 9;  // velocity * 512
        end
    end

    //////////////////////////////////////////////////////////////////////
    // envelope
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_n = state;
        env_n   = env;
        env_sum = {1'b0, env} + {1'b0, ATTACK_STEP};
        if (trig) begin
            case (state)
                ENV_ATTACK: begin
                    if (env_sum >= {1'b0, peak}) begin
                        env_n   = peak;         // capped
                        state_n = ENV_SUSTAIN;
                    end else begin
                        env_n = env_sum[ENV_BITS-1:0];
                    end
                end
                ENV_RELEASE: begin
                    if (env <= RELEASE_STEP) begin
                        env_n   = '0;
                        state_n = ENV_IDLE;
                    end else begin
                        env_n = env - RELEASE_STEP;
                    end
                end
                default: begin
                    // idle and sustain hold the level
                end
            endcase
        end
        if (cmd.stop && state != ENV_IDLE) begin
            state_n = ENV_RELEASE;
        end
        // restart keeps the level, no click
        if (cmd.start) begin
            state_n = ENV_ATTACK;
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            state <= ENV_IDLE;
            env   <= '0;
        end else begin
            state <= state_n;
            env   <= env_n;
        end
    end

    // free rises the cycle after idle is reached
    always_ff @(posedge reg_clk) begin
        if (rst) begin
            free <= 1'b1;
        end else if (cmd.start) begin
            free <= 1'b0;
        end else if (state == ENV_IDLE) begin
            free <= 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // sample out
    //////////////////////////////////////////////////////////////////////

    assign prod = saw * $signed({1'b0, env_n});

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            sample <= '0;
        end else if (trig) begin
            sample <= (state_n == ENV_IDLE) ? '0
                                            : prod[PROD_BITS-1 -: AUD_BIT_DEPTH];
        end
    end

    // silent voice whenever it reports free
    a_free_silent: assert property (@(posedge reg_clk) disable iff (rst)
        free |-> sample == '0)
        else $error("free voice with nonzero sample");

endmodule

// File: synthesizer.sv
// two channel polyphonic synthesizer voice subsystem, top level
// note events in, left and right samples out on every trig
`timescale 1ns/1ps

module synthesizer #(
    parameter int VOICES        = 8,
    parameter int AUD_BIT_DEPTH = 24
) (
    input  logic                               reg_clk,
    input  logic                               rst,
    input  logic                               note_valid,   // one cycle strobe
    input  midi_pkg::note_event_t              note,
    input  logic                               trig,         // sample strobe
    output logic signed [AUD_BIT_DEPTH-1:0]    lsound_out,
    output logic signed [AUD_BIT_DEPTH-1:0]    rsound_out,
    output logic [synth_pkg::clogb2(VOICES):0] active_keys,
    output logic [VOICES-1:0]                  voice_free,
    output logic                               note_dropped,
    output logic                               run
);
    import midi_pkg::*;

    voice_cmd_t                      voice_cmd [VOICES];
    logic signed [AUD_BIT_DEPTH-1:0] voice_sample [VOICES];

    voice_allocator #(.VOICES(VOICES)) u_alloc (
        .reg_clk      ( reg_clk ),
        .rst          ( rst ),
        .note_valid   ( note_valid ),     // input
        .note         ( note ),           // input
        .voice_free   ( voice_free ),     // input from voices
        .cmd          ( voice_cmd ),      // output to voices
        .note_dropped ( note_dropped )
    );

    // voice bank
    for (genvar v = 0; v < VOICES; v++) begin : g_voice
        synth_voice #(.AUD_BIT_DEPTH(AUD_BIT_DEPTH)) u_voice (
            .reg_clk ( reg_clk ),
            .rst     ( rst ),
            .trig    ( trig ),
            .cmd     ( voice_cmd[v] ),
            .free    ( voice_free[v] ),
            .sample  ( voice_sample[v] )
        );
    end

    voice_mixer #(
        .VOICES        ( VOICES ),
        .AUD_BIT_DEPTH ( AUD_BIT_DEPTH )
    ) u_mixer (
        .reg_clk     ( reg_clk ),
        .rst         ( rst ),
        .trig        ( trig ),
        .samples     ( voice_sample ),
        .voice_free  ( voice_free ),
        .lsound_out  ( lsound_out ),   // left
        .rsound_out  ( rsound_out ),   // right
        .active_keys ( active_keys ),
        .run         ( run )
    );

endmodule

// File: tb_synthesizer.sv
// testbench for the synthesizer top level
// random note traffic checked against a small allocation model by assertions
`timescale 1ns/1ps

module tb_synthesizer;
    import midi_pkg::*;

    localparam int VOICES        = 8;
    localparam int AUD_BIT_DEPTH = 24;
    localparam int KW            = $clog2(VOICES) + 1;     // active_keys width
    localparam int TRIG_PERIOD   = 16;                     // cycles per sample
    localparam int N_EVENTS      = 64;                     // note events, upper bound
    localparam int RELEASE_TRIGS = (127 * 512) / 128 + 1;  // full scale release
    localparam longint TIMEOUT_NS =
        longint'(N_EVENTS) * RELEASE_TRIGS * TRIG_PERIOD * 10 + 50000;

    localparam logic [VOICES-1:0] ALL_FREE  = {VOICES{1'b1}};
    localparam logic [VOICES-1:0] ODD_MASK  = {(VOICES / 2){2'b10}};
    localparam logic [VOICES-1:0] EVEN_MASK = {(VOICES / 2){2'b01}};

    logic                            reg_clk;
    logic                            rst;
    logic                            note_valid;
    note_event_t                     note;
    logic                            trig;
    logic signed [AUD_BIT_DEPTH-1:0] lsound_out;
    logic signed [AUD_BIT_DEPTH-1:0] rsound_out;
    logic [KW-1:0]                   active_keys;
    logic [VOICES-1:0]               voice_free;
    logic                            note_dropped;
    logic                            run;

    // reference model state
    logic [VOICES-1:0] busy_q;      // voice taken
    logic [VOICES-1:0] rel_q;       // stop sent, free bit may rise
    logic [6:0]        key_q [VOICES];
    logic [VOICES-1:0] clr_q;       // bit expected to fall
    logic [VOICES-1:0] clr_d;
    logic              drop_q;      // expected note_dropped
    logic [VOICES-1:0] free_q;      // voice_free one cycle back
    logic [VOICES-1:0] fell;
    logic [VOICES-1:0] rose;
    logic [VOICES-1:0] busy_seen;   // busy as active_keys reports it
    logic [31:0]       seed;
    int                tcnt;

    assign fell = free_q & ~voice_free;
    assign rose = voice_free & ~free_q;

    // a new voice shows up in active_keys 3 cycles after its strobe
    assign busy_seen = busy_q & ~clr_q & ~clr_d;

    synthesizer #(.VOICES(VOICES), .AUD_BIT_DEPTH(AUD_BIT_DEPTH)) dut (.*);

    always #5 reg_clk = ~reg_clk;

    ////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [KW-1:0] busy_count(input logic [VOICES-1:0] busy);
        logic [KW-1:0] n;
        n = '0;
        for (int i = 0; i < VOICES; i++) begin
            n = n + KW'(busy[i]);
        end
        return n;
    endfunction

    task automatic stop_failed(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic value_error(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        stop_failed($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    // called just after a rising edge
    task automatic send_note(input logic on, input logic [6:0] key, input logic [6:0] vel);
        note_valid <= 1'b1;
        note       <= {on, key, vel};
        @(posedge reg_clk);
        note_valid <= 1'b0;
        repeat (3) @(posedge reg_clk);   // model settles before the next pick
    endtask

    task automatic send_on(input logic [6:0] key);
        seed = lcg_next(seed);
        send_note(1'b1, key, seed[30:24] | 7'd16);
    endtask

    task automatic send_off(input logic [6:0] key);
        send_note(1'b0, key, 7'd0);
    endtask

    // never a key in release, a restart there races the free bit
    task automatic pick_key(input logic allow_held, output logic [6:0] key);
        logic ok;
        ok  = 1'b0;
        key = '0;
        while (!ok) begin
            seed = lcg_next(seed);
            key  = seed[22:16];
            ok   = 1'b1;
            for (int i = 0; i < VOICES; i++) begin
                if (busy_q[i] && key_q[i] == key && (rel_q[i] || !allow_held)) begin
                    ok = 1'b0;
                end
            end
        end
    endtask

    task automatic wait_free(input logic [VOICES-1:0] mask);
        while ((voice_free & mask) != mask) begin
            @(posedge reg_clk);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // sample strobe and reference model
    ////////////////////////////////////////////////////////////////////

    always @(posedge reg_clk) begin
        if (rst) begin
            tcnt <= 0;
            trig <= 1'b0;
        end else begin
            tcnt <= (tcnt == TRIG_PERIOD - 1) ? 0 : tcnt + 1;
            trig <= (tcnt == TRIG_PERIOD - 1);   // one cycle pulse
        end
    end

    always @(posedge reg_clk) begin : ref_model
        logic [VOICES-1:0] nb;
        logic [VOICES-1:0] nr;
        logic [VOICES-1:0] clr;
        logic              drop;
        logic              hit;
        logic              has_free;
        int                hit_i;
        int                free_i;
        free_q <= voice_free;
        if (rst) begin
            busy_q <= '0;
            rel_q  <= '0;
            clr_q  <= '0;
            clr_d  <= '0;
            drop_q <= 1'b0;
        end else begin
            nb       = busy_q & ~rose;   // free again as seen at the port
            nr       = rel_q & nb;
            clr      = '0;
            drop     = 1'b0;
            hit      = 1'b0;
            has_free = 1'b0;
            hit_i    = 0;
            free_i   = 0;
            for (int i = VOICES - 1; i >= 0; i--) begin   // lowest index wins
                if (nb[i] && key_q[i] == note.key) begin
                    hit   = 1'b1;
                    hit_i = i;
                end
                if (!nb[i]) begin
                    has_free = 1'b1;
                    free_i   = i;
                end
            end
            if (note_valid && note.on) begin
                if (hit) begin
                    nr[hit_i] = 1'b0;         // retrigger, no new bit
                end else if (has_free) begin
                    nb[free_i]     = 1'b1;
                    clr[free_i]    = 1'b1;
                    key_q[free_i] <= note.key;
                end else begin
                    drop = 1'b1;
                end
            end else if (note_valid && hit) begin
                nr[hit_i] = 1'b1;             // stop sent
            end
            busy_q <= nb;
            rel_q  <= nr;
            clr_q  <= clr;
            clr_d  <= clr_q;
            drop_q <= drop;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////

    a_reset_free: assert property (@(posedge reg_clk) $fell(rst) |-> voice_free == ALL_FREE)
        else value_error("voice_free", 32'(ALL_FREE), 32'($sampled(voice_free)));
    a_reset_out: assert property (@(posedge reg_clk) $fell(rst) |->
        active_keys == '0 && !run && lsound_out == '0 && rsound_out == '0)
        else stop_failed("active_keys, run or sound outputs not cleared after reset");

    // chosen bit falls 2 cycles after the strobe, no other bit falls
    a_free_fall: assert property (@(posedge reg_clk) disable iff (rst) fell == clr_d)
        else value_error("voice_free falling bits", 32'($sampled(clr_d)), 32'($sampled(fell)));
    a_free_rise: assert property (@(posedge reg_clk) disable iff (rst) (rose & ~rel_q) == '0)
        else value_error("voice_free rising bits", 32'($sampled(rose & rel_q)),
                         32'($sampled(rose)));
    a_drop: assert property (@(posedge reg_clk) disable iff (rst) note_dropped == drop_q)
        else value_error("note_dropped", 32'($sampled(drop_q)), 32'($sampled(note_dropped)));
    a_keys: assert property (@(posedge reg_clk) disable iff (rst)
        active_keys == busy_count(busy_seen))
        else value_error("active_keys", 32'(busy_count($sampled(busy_seen))),
                         32'($sampled(active_keys)));
    a_run: assert property (@(posedge reg_clk) disable iff (rst)
        run == (busy_seen != '0))
        else value_error("run", 32'($sampled(busy_seen) != '0), 32'($sampled(run)));

    a_right_quiet: assert property (@(posedge reg_clk) disable iff (rst)
        &(voice_free | EVEN_MASK) |-> rsound_out == '0)
        else value_error("rsound_out", 32'h0, 32'($sampled(rsound_out)));
    a_left_quiet: assert property (@(posedge reg_clk) disable iff (rst)
        &(voice_free | ODD_MASK) |-> lsound_out == '0)
        else value_error("lsound_out", 32'h0, 32'($sampled(lsound_out)));
    a_left_timing: assert property (@(posedge reg_clk) disable iff (rst)
        lsound_out != $past(lsound_out) |-> $past(trig, 2))
        else stop_failed("lsound_out changed without a trig two cycles earlier");
    a_right_timing: assert property (@(posedge reg_clk) disable iff (rst)
        rsound_out != $past(rsound_out) |-> $past(trig, 2))
        else stop_failed("rsound_out changed without a trig two cycles earlier");

    ////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////

    initial begin : watchdog
        #(TIMEOUT_NS);
        stop_failed("watchdog timeout, the run did not finish in time");
    end

    initial begin : stimulus
        logic [6:0] key;
        int         idx;
        reg_clk    = 1'b0;
        rst        = 1'b1;
        note_valid = 1'b0;
        note       = '0;
        trig       = 1'b0;
        seed       = 32'h0c6f15ec;
        repeat (3) @(posedge reg_clk);
        rst <= 1'b0;
        repeat (2) @(posedge reg_clk);

        for (int i = 0; i < VOICES; i++) begin   // fill all voices
            pick_key(1'b0, key);
            send_on(key);
        end
        send_on(key_q[VOICES / 2]);              // held key
        pick_key(1'b0, key);
        send_on(key);                            // nothing free, dropped
        repeat (TRIG_PERIOD * 4) @(posedge reg_clk);

        // only even voices left sounding
        for (int i = 1; i < VOICES; i += 2) begin
            send_off(key_q[i]);
        end
        wait_free(ODD_MASK);
        repeat (TRIG_PERIOD * 8) @(posedge reg_clk);
        for (int i = 0; i < VOICES; i += 2) begin
            send_off(key_q[i]);
        end
        wait_free(ALL_FREE);
        repeat (TRIG_PERIOD * 4) @(posedge reg_clk);

        // voices 0 and 1, then 0 released so only the right side sounds
        pick_key(1'b0, key);
        send_on(key);
        pick_key(1'b0, key);
        send_on(key);
        send_off(key_q[0]);
        wait_free(VOICES'(1));
        repeat (TRIG_PERIOD * 8) @(posedge reg_clk);
        send_off(key_q[1]);
        wait_free(ALL_FREE);

        // random traffic
        for (int n = 0; n < 32; n++) begin
            seed = lcg_next(seed);
            if (seed[27:26] == 2'd0) begin
                pick_key(1'b1, key);
                send_off(key);                   // may match nothing
            end else if (seed[25] && (busy_q & ~rel_q) != '0) begin
                idx = int'(seed[3:0]) % VOICES;
                while (!(busy_q[idx] && !rel_q[idx])) begin
                    idx = (idx + 1) % VOICES;
                end
                send_off(key_q[idx]);
            end else begin
                pick_key(1'b1, key);
                send_on(key);
            end
            repeat (int'(seed[8:4])) @(posedge reg_clk);
        end

        for (int i = 0; i < VOICES; i++) begin
            if (busy_q[i] && !rel_q[i]) begin
                send_off(key_q[i]);
            end
        end
        wait_free(ALL_FREE);
        repeat (TRIG_PERIOD * 2) @(posedge reg_clk);

        $display("Test OK");
        $finish;
    end

endmodule

// File: voice_allocator.sv
// voice allocation for incoming note events
// keeps the key held by each voice and turns events into voice commands
`timescale 1ns/1ps

module voice_allocator #(
    parameter int VOICES = 8
) (
    input  logic                  reg_clk,
    input  logic                  rst,
    input  logic                  note_valid,    // one cycle strobe
    input  midi_pkg::note_event_t note,
    input  logic [VOICES-1:0]     voice_free,    // levels from the voices
    output midi_pkg::voice_cmd_t  cmd [VOICES],  // registered commands
    output logic                  note_dropped   // no voice for a note on
);
    import synth_pkg::*;
    import midi_pkg::*;

    localparam int V_WIDTH = clogb2(VOICES);

    logic [KEY_BITS-1:0] key_tab [VOICES];  // key per voice
    logic [VOICES-1:0]   pend;              // start issued last cycle
    logic [VOICES-1:0]   busy;
    logic                hit;
    logic                have_free;
    logic [V_WIDTH-1:0]  hit_idx;
    logic [V_WIDTH-1:0]  free_idx;
    logic [V_WIDTH-1:0]  sel_idx;
    logic                issue;
    logic                drop_n;
    voice_cmd_t          cmd_n;
    logic [2*VOICES-1:0] cmd_bits;

    //////////////////////////////////////////////////////////////////////
    // voice search
    //////////////////////////////////////////////////////////////////////

    // free bit only falls one cycle after the start, so cover that gap
    always_comb begin
        for (int i = 0; i < VOICES; i++) begin
            pend[i] = cmd[i].start;
        end
        busy = ~voice_free | pend;
    end

    // downward scan so the lowest index wins
    always_comb begin
        hit       = 1'b0;
        hit_idx   = '0;
        have_free = 1'b0;
        free_idx  = '0;
        for (int i = VOICES - 1; i >= 0; i--) begin
            if (busy[i] && key_tab[i] == note.key) begin
                hit     = 1'b1;
                hit_idx = V_WIDTH'(i);
            end
            if (!busy[i]) begin
                have_free = 1'b1;
                free_idx  = V_WIDTH'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // command decision
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cmd_n          = '0;
        cmd_n.key      = note.key;
        cmd_n.velocity = note.velocity;
        sel_idx        = '0;
        issue          = 1'b0;
        drop_n         = 1'b0;
        if (note_valid) begin
            if (note.on) begin
                if (hit) begin                  // same key held, retrigger
                    issue       = 1'b1;
                    sel_idx     = hit_idx;
                    cmd_n.start = 1'b1;
                end else if (have_free) begin
                    issue       = 1'b1;
                    sel_idx     = free_idx;
                    cmd_n.start = 1'b1;
                end else begin
                    drop_n = 1'b1;              // all voices taken
                end
            end else if (hit) begin
                issue      = 1'b1;
                sel_idx    = hit_idx;
                cmd_n.stop = 1'b1;
            end
            // note off with no match falls through
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            for (int i = 0; i < VOICES; i++) begin
                cmd[i] <= '0;
            end
            note_dropped <= 1'b0;
        end else begin
            for (int i = 0; i < VOICES; i++) begin
                cmd[i] <= (issue && sel_idx == V_WIDTH'(i)) ? cmd_n : '0;
            end
            note_dropped <= drop_n;
        end
    end

    // key table only read for busy voices
    always_ff @(posedge reg_clk) begin
        if (issue && cmd_n.start) begin
            key_tab[sel_idx] <= note.key;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < VOICES; i++) begin
            cmd_bits[2*i]   = cmd[i].start;
            cmd_bits[2*i+1] = cmd[i].stop;
        end
    end

    a_one_cmd: assert property (@(posedge reg_clk) disable iff (rst)
        $countones(cmd_bits) <= 1)
        else $error("more than one voice command in a cycle");

    a_drop_src: assert property (@(posedge reg_clk) disable iff (rst)
        note_dropped |-> $past(note_valid && note.on))
        else $error("note_dropped without a note on");

endmodule

// File: voice_mixer.sv
// two channel mixer, even voices left and odd voices right
// also reports how many voices are busy
`timescale 1ns/1ps

module voice_mixer #(
    parameter int VOICES        = 8,
    parameter int AUD_BIT_DEPTH = 24
) (
    input  logic                               reg_clk,
    input  logic                               rst,
    input  logic                               trig,
    input  logic signed [AUD_BIT_DEPTH-1:0]    samples [VOICES],
    input  logic [VOICES-1:0]                  voice_free,
    output logic signed [AUD_BIT_DEPTH-1:0]    lsound_out,
    output logic signed [AUD_BIT_DEPTH-1:0]    rsound_out,
    output logic [synth_pkg::clogb2(VOICES):0] active_keys,
    output logic                               run
);
    import synth_pkg::*;

    localparam int V_WIDTH  = clogb2(VOICES);
    localparam int SHIFT    = clogb2(VOICES / 2);   // headroom per channel
    localparam int SUM_BITS = AUD_BIT_DEPTH + SHIFT;

    logic                       trig_d;   // voices settle one cycle after trig
    logic signed [SUM_BITS-1:0] lsum;
    logic signed [SUM_BITS-1:0] rsum;
    logic [V_WIDTH:0]           key_cnt;

    always_comb begin
        lsum = '0;
        rsum = '0;
        for (int i = 0; i < VOICES / 2; i++) begin
            lsum = lsum + samples[2*i];     // even
            rsum = rsum + samples[2*i+1];   // odd
        end
    end

    // busy voices are the cleared free bits
    always_comb begin
        key_cnt = '0;
        for (int i = 0; i < VOICES; i++) begin
            key_cnt = key_cnt + (V_WIDTH + 1)'(!voice_free[i]);
        end
    end

    always_ff @(posedge reg_clk) begin
        if (rst) begin
            trig_d      <= 1'b0;
            lsound_out  <= '0;
            rsound_out  <= '0;
            active_keys <= '0;
            run         <= 1'b0;
        end else begin
            trig_d      <= trig;
            active_keys <= key_cnt;
            run         <= (key_cnt != '0);
            if (trig_d) begin
                // top bits of the sum, same as an arithmetic shift by SHIFT
                lsound_out <= lsum[SUM_BITS-1 -: AUD_BIT_DEPTH];
                rsound_out <= rsum[SUM_BITS-1 -: AUD_BIT_DEPTH];
            end
        end
    end

endmodule
